/* sources.f */
common/conv_geom_pkg.sv
common/conv_arith_pkg.sv
window/scan_ctrl.sv
window/window_fetch.sv
pe/conv_mac.sv
pe/relu_maxpool.sv
verilog/conv_top.sv
sim/conv_assert.sv
sim/conv_checker.sv
sim/tb_conv_top.sv

/* Makefile */
TOP = tb_conv_top

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* sim/tb_conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_conv_top;
	import conv_geom_pkg::*;
	import conv_arith_pkg::*;

	localparam int IMG_W       = DEF_IMG_W;
	localparam int IMG_H       = DEF_IMG_H;
	localparam int NPIX        = IMG_W * IMG_H;
	localparam int PER_RUN     = (IMG_W / 2) * (IMG_H / 2);
	localparam int NUM_RUNS    = 7;
	localparam int RUN_CYCLES  = NPIX + 20;
	localparam int LOAD_CYCLES = NPIX + TAPS + 8; // image, weights and bias writes
	localparam int WATCHDOG_CYCLES = NUM_RUNS * (RUN_CYCLES + LOAD_CYCLES) + 50;

	logic    clk;
	logic    i_reset;
	logic    i_wr_en;
	wr_sel_t i_wr_sel;
	logic [11:0] i_wr_addr;
	bias_t   i_wr_data;
	logic    i_start;
	logic    o_busy, o_out_valid, o_done;
	pool_t   o_out_data;

	integer seed = 64;
	int     runs = 0;
	int     tb_errors = 0;
	int     chk_errors, chk_outputs, chk_pending;

	conv_top dut_i (
		.clk(clk), .i_reset(i_reset),
		.i_wr_en(i_wr_en), .i_wr_sel(i_wr_sel), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_start(i_start),
		.o_busy(o_busy), .o_out_valid(o_out_valid), .o_out_data(o_out_data), .o_done(o_done)
	);

	conv_checker #(.IMG_W(IMG_W), .IMG_H(IMG_H), .OUT_SHIFT(DEF_OUT_SHIFT)) checker_i (
		.clk(clk), .i_reset(i_reset),
		.i_wr_en(i_wr_en), .i_wr_sel(i_wr_sel), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data),
		.i_start(i_start), .i_busy(o_busy),
		.i_out_valid(o_out_valid), .i_out_data(o_out_data), .i_done(o_done),
		.o_errors(chk_errors), .o_outputs(chk_outputs), .o_pending(chk_pending)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	task automatic write_word(wr_sel_t sel, int addr, int data);
		@(posedge clk);
		#1;
		i_wr_en   = 1'b1;
		i_wr_sel  = sel;
		i_wr_addr = 12'(addr);
		i_wr_data = bias_t'(data);
	endtask

	task automatic end_writes();
		@(posedge clk);
		#1 i_wr_en = 1'b0;
	endtask

	task automatic load_image_random();
		for (int a = 0; a < NPIX; a++)
			write_word(WR_IMAGE, a, $random(seed) & 255);
		end_writes();
	endtask

	task automatic load_image_fill(int value);
		for (int a = 0; a < NPIX; a++)
			write_word(WR_IMAGE, a, value);
		end_writes();
	endtask

	// weights in -(span-1) .. span-1
	task automatic load_weights_random(int span);
		for (int t = 0; t < TAPS; t++)
			write_word(WR_WEIGHT, t, $random(seed) % span);
		end_writes();
	endtask

	task automatic load_weights_fill(int value);
		for (int t = 0; t < TAPS; t++)
			write_word(WR_WEIGHT, t, value);
		end_writes();
	endtask

	task automatic load_bias(int value);
		write_word(WR_BIAS, 0, value);
		end_writes();
	endtask

	task automatic pulse_start();
		@(posedge clk);
		#1 i_start = 1'b1;
		@(posedge clk);
		#1 i_start = 1'b0;
	endtask

	task automatic wait_done();
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk);
			cycles++;
		end while (!o_done && cycles < RUN_CYCLES);
		if (!o_done) begin
			tb_errors++;
			$display("timeout: no o_done within %0d cycles of the start", RUN_CYCLES);
		end else begin
			if (!o_busy) begin
				tb_errors++;
				$display("[FAIL] %0t: o_busy low in the o_done cycle", $time);
			end
			@(negedge clk);
			if (o_busy) begin
				tb_errors++;
				$display("[FAIL] %0t: o_busy still high the cycle after o_done", $time);
			end
		end
	endtask

	task automatic run_once(bit stray_starts);
		pulse_start();
		runs++;
		if (stray_starts) begin
			repeat (2) @(posedge clk);
			#1 i_start = 1'b1; // early in the scan
			@(posedge clk);
			#1 i_start = 1'b0;
			repeat (NPIX - 2) @(posedge clk);
			#1 i_start = 1'b1; // between the last window and o_done
			@(posedge clk);
			#1 i_start = 1'b0;
		end
		wait_done();
	endtask

	initial begin
		i_reset   = 1'b1;
		i_wr_en   = 1'b0;
		i_wr_sel  = WR_IMAGE;
		i_wr_addr = '0;
		i_wr_data = '0;
		i_start   = 1'b0;
		repeat (4) @(posedge clk);
		#1 i_reset = 1'b0;
		@(negedge clk);
		if (o_busy || o_out_valid || o_done) begin
			tb_errors++;
			$display("[FAIL] %0t: control outputs not low after reset", $time);
		end

		// random data, full range weights first, then small ones
		for (int r = 0; r < 3; r++) begin
			load_image_random();
			load_weights_random((r == 0) ? 128 : 8);
			load_bias((r == 0) ? $random(seed) : $random(seed) % 2048);
			run_once(r == 1);
		end

		// zero padding, constant image
		load_image_fill(255);
		load_weights_fill(1);
		load_bias(0);
		run_once(1'b0);
		load_weights_fill(-1); // borders now win the max
		load_bias(2400);
		run_once(1'b0);

		// relu clamp, then saturation
		load_image_random();
		load_weights_random(3);
		load_bias(-32768);
		run_once(1'b0);
		load_bias(32767);
		run_once(1'b0);

		repeat (20) @(negedge clk); // catch stray outputs
		if (chk_outputs != runs * PER_RUN) begin
			tb_errors++;
			$display("wrong number of outputs: got %0d, expected %0d", chk_outputs, runs * PER_RUN);
		end
		if (chk_pending != 0) begin
			tb_errors++;
			$display("%0d expected outputs never appeared", chk_pending);
		end
		$display("runs %0d, outputs %0d, checker errors %0d, testbench errors %0d",
			runs, chk_outputs, chk_errors, tb_errors);
		if (chk_errors + tb_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* sim/conv_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_checker #(
	parameter int IMG_W     = conv_geom_pkg::DEF_IMG_W,
	parameter int IMG_H     = conv_geom_pkg::DEF_IMG_H,
	parameter int OUT_SHIFT = conv_arith_pkg::DEF_OUT_SHIFT
) (
	input  wire                     clk,
	input  wire                     i_reset,
	input  wire                     i_wr_en,
	input  conv_geom_pkg::wr_sel_t  i_wr_sel,
	input  wire  [11:0]             i_wr_addr,
	input  conv_arith_pkg::bias_t   i_wr_data,
	input  wire                     i_start,
	input  wire                     i_busy,
	input  wire                     i_out_valid,
	input  conv_arith_pkg::pool_t   i_out_data,
	input  wire                     i_done,
	output int                      o_errors,
	output int                      o_outputs,
	output int                      o_pending
);
	import conv_geom_pkg::*;

	localparam int NPIX = IMG_W * IMG_H;

	int img [NPIX];
	int wts [9];
	int bias = 0;
	int expected [$];
	int errors = 0;
	int outputs = 0;
	int exp_val;

	assign o_errors  = errors;
	assign o_outputs = outputs;
	assign o_pending = expected.size();

	// one window: zero padded 3x3 sum, bias, relu, shift, clip
	function automatic int window_value(int r, int c);
		int acc;
		int rr;
		int cc;
		acc = bias;
		for (int t = 0; t < 9; t++) begin
			rr = r + t / 3 - 1;
			cc = c + t % 3 - 1;
			if (rr >= 0 && rr < IMG_H && cc >= 0 && cc < IMG_W)
				acc += img[rr * IMG_W + cc] * wts[t];
		end
		if (acc < 0)
			return 0;
		acc = acc >>> OUT_SHIFT;
		return (acc > 255) ? 255 : acc;
	endfunction

	function automatic void build_expected();
		int best;
		int v;
		for (int pr = 0; pr < IMG_H / 2; pr++) begin
			for (int pc = 0; pc < IMG_W / 2; pc++) begin
				best = 0;
				for (int q = 0; q < 4; q++) begin
					v = window_value(2 * pr + q / 2, 2 * pc + q % 2);
					if (v > best)
						best = v;
				end
				expected.push_back(best); // raster order
			end
		end
	endfunction

	always @(negedge clk) begin
		if (i_reset) begin
			expected.delete();
		end else begin
			if (i_wr_en) begin
				case (i_wr_sel)
					WR_IMAGE:  if (i_wr_addr < NPIX) img[i_wr_addr] = int'(i_wr_data[7:0]);
					WR_WEIGHT: if (i_wr_addr < 9) wts[i_wr_addr] = int'($signed(i_wr_data[7:0]));
					WR_BIAS:   bias = int'(i_wr_data);
					default: ;
				endcase
			end
			if (i_out_valid) begin
				outputs++;
				if (expected.size() == 0) begin
					errors++;
					$display("output at %0t with no run expecting it", $time);
				end else begin
					exp_val = expected.pop_front();
					if (int'(i_out_data) != exp_val) begin
						errors++;
						$display("[FAIL] %0t: output %0d, expected %0d", $time, i_out_data, exp_val);
					end
					if (i_done != (expected.size() == 0)) begin
						errors++;
						$display("[FAIL] %0t: o_done %0b with %0d outputs left",
							$time, i_done, expected.size());
					end
				end
			end else if (i_done) begin
				errors++;
				$display("[FAIL] %0t: o_done without o_out_valid", $time);
			end
			if (i_start && !i_busy) // taken only when idle
				build_expected();
		end
	end

endmodule

`default_nettype wire

/* sim/conv_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_assert (
	input wire clk,
	input wire i_reset,
	input wire i_busy,
	input wire i_out_valid,
	input wire i_done
);

	outputs_while_busy: assert property (@(posedge clk) disable iff (i_reset)
		(i_out_valid || i_done) |-> i_busy)
		else $error("o_out_valid or o_done high while o_busy is low");

	done_one_cycle: assert property (@(posedge clk) disable iff (i_reset)
		i_done |-> !$past(i_done))
		else $error("o_done held for more than one cycle");

	// one pooled result per four windows
	valid_spacing: assert property (@(posedge clk) disable iff (i_reset)
		i_out_valid |-> !$past(i_out_valid, 1) && !$past(i_out_valid, 2) && !$past(i_out_valid, 3))
		else $error("o_out_valid again within 4 cycles");

endmodule

bind conv_top conv_assert assert_i (
	.clk(clk), .i_reset(i_reset),
	.i_busy(o_busy), .i_out_valid(o_out_valid), .i_done(o_done)
);

`default_nettype wire

/* verilog/conv_top.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_top #(
	parameter int IMG_W     = conv_geom_pkg::DEF_IMG_W,
	parameter int IMG_H     = conv_geom_pkg::DEF_IMG_H,
	parameter int OUT_SHIFT = conv_arith_pkg::DEF_OUT_SHIFT
) (
	input  wire                     clk,
	input  wire                     i_reset,
	input  wire                     i_wr_en,
	input  conv_geom_pkg::wr_sel_t  i_wr_sel,
	input  wire  [11:0]             i_wr_addr,
	input  conv_arith_pkg::bias_t   i_wr_data,
	input  wire                     i_start,
	output logic                    o_busy,
	output logic                    o_out_valid,
	output conv_arith_pkg::pool_t   o_out_data,
	output logic                    o_done
);
	import conv_geom_pkg::*;
	import conv_arith_pkg::*;

	logic      img_we, wt_we, bias_we;
	logic      win_valid, win_last;
	coord_t    win_row, win_col;
	tap_mask_t win_mask;
	pixel_t    taps [TAPS];
	logic      tap_valid, tap_last;
	acc_t      acc;
	logic      acc_valid, acc_last;

	assign img_we  = i_wr_en && (i_wr_sel == WR_IMAGE);
	assign wt_we   = i_wr_en && (i_wr_sel == WR_WEIGHT);
	assign bias_we = i_wr_en && (i_wr_sel == WR_BIAS);

	scan_ctrl #(.IMG_W(IMG_W), .IMG_H(IMG_H)) scan_i (
		.clk(clk), .i_reset(i_reset), .i_start(i_start),
		.o_busy(o_busy), .o_win_valid(win_valid),
		.o_win_row(win_row), .o_win_col(win_col),
		.o_win_mask(win_mask), .o_win_last(win_last)
	);

	window_fetch #(.IMG_W(IMG_W), .IMG_H(IMG_H)) fetch_i (
		.clk(clk), .i_reset(i_reset),
		.i_wr_en(img_we), .i_wr_addr(i_wr_addr), .i_wr_data(i_wr_data[7:0]),
		.i_win_valid(win_valid), .i_win_row(win_row), .i_win_col(win_col),
		.i_win_mask(win_mask), .i_win_last(win_last),
		.o_taps(taps), .o_valid(tap_valid), .o_last(tap_last)
	);

	conv_mac mac_i (
		.clk(clk), .i_reset(i_reset),
		.i_wt_we(wt_we), .i_bias_we(bias_we),
		.i_wt_addr(i_wr_addr[3:0]), .i_wr_data(i_wr_data),
		.i_taps(taps), .i_valid(tap_valid), .i_last(tap_last),
		.o_acc(acc), .o_valid(acc_valid), .o_last(acc_last)
	);

	relu_maxpool #(.OUT_SHIFT(OUT_SHIFT)) pool_i (
		.clk(clk), .i_reset(i_reset),
		.i_acc(acc), .i_valid(acc_valid), .i_last(acc_last),
		.o_out_valid(o_out_valid), .o_out_data(o_out_data), .o_done(o_done)
	);

endmodule

`default_nettype wire

/* pe/relu_maxpool.sv */
`timescale 1ns/1ps
`default_nettype none

module relu_maxpool #(
	parameter int OUT_SHIFT = conv_arith_pkg::DEF_OUT_SHIFT
) (
	input  wire                    clk,
	input  wire                    i_reset,
	input  conv_arith_pkg::acc_t   i_acc,
	input  wire                    i_valid,
	input  wire                    i_last,
	output logic                   o_out_valid,
	output conv_arith_pkg::pool_t  o_out_data,
	output logic                   o_done
);
	import conv_arith_pkg::*;

	acc_t       shifted;
	pool_t      act;      // activated result of this window
	pool_t      max_r;    // running max of the group
	pool_t      max_nxt;
	logic [1:0] cnt;

	assign shifted = i_acc >>> OUT_SHIFT;

	always_comb begin
		if (i_acc < 0)
			act = '0;
		else if (shifted > acc_t'(255))
			act = 8'd255; // saturate
		else
			act = pool_t'(shifted);
	end

	// first of four starts a new group
	assign max_nxt = ((cnt == 2'd0) || (act > max_r)) ? act : max_r;

	always_ff @(posedge clk) begin
		if (i_valid)
			max_r <= max_nxt;
		if (i_valid && (cnt == 2'd3))
			o_out_data <= max_nxt;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			cnt         <= 2'd0;
			o_out_valid <= 1'b0;
			o_done      <= 1'b0;
		end else begin
			if (i_valid)
				cnt <= cnt + 2'd1;
			o_out_valid <= i_valid && (cnt == 2'd3);
			o_done      <= i_valid && (cnt == 2'd3) && i_last;
		end
	end

endmodule

`default_nettype wire

/* pe/conv_mac.sv */
`timescale 1ns/1ps
`default_nettype none

module conv_mac (
	input  wire                     clk,
	input  wire                     i_reset,
	input  wire                     i_wt_we,
	input  wire                     i_bias_we,
	input  wire  [3:0]              i_wt_addr,
	input  conv_arith_pkg::bias_t   i_wr_data,
	input  conv_arith_pkg::pixel_t  i_taps [conv_geom_pkg::TAPS],
	input  wire                     i_valid,
	input  wire                     i_last,
	output conv_arith_pkg::acc_t    o_acc,
	output logic                    o_valid,
	output logic                    o_last
);
	import conv_geom_pkg::*;
	import conv_arith_pkg::*;

	localparam int PROD_W = 17; // s8 x u8

	weight_t                  wt [TAPS];
	bias_t                    bias;
	logic signed [PROD_W-1:0] prod [TAPS];
	logic                     p_valid, p_last;
	acc_t                     sum;

	always_ff @(posedge clk) begin
		if (i_wt_we && (i_wt_addr < 4'(TAPS)))
			wt[i_wt_addr] <= weight_t'(i_wr_data[7:0]);
		if (i_bias_we)
			bias <= i_wr_data;
	end

	// stage 1, pixels zero-extended so they stay unsigned
	always_ff @(posedge clk) begin
		if (i_valid) begin
			for (int t = 0; t < TAPS; t++) begin
				prod[t] <= $signed({1'b0, i_taps[t]}) * wt[t];
			end
		end
	end

	// adder tree, sign-extended to accumulator width
	always_comb begin
		sum = acc_t'(bias);
		for (int t = 0; t < TAPS; t++) begin
			sum = sum + acc_t'(prod[t]);
		end
	end

	// stage 2
	always_ff @(posedge clk) begin
		if (p_valid)
			o_acc <= sum;
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			p_valid <= 1'b0;
			p_last  <= 1'b0;
			o_valid <= 1'b0;
			o_last  <= 1'b0;
		end else begin
			p_valid <= i_valid;
			p_last  <= i_valid && i_last;
			o_valid <= p_valid;
			o_last  <= p_valid && p_last;
		end
	end

endmodule

`default_nettype wire

/* window/window_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module window_fetch #(
	parameter int IMG_W = conv_geom_pkg::DEF_IMG_W,
	parameter int IMG_H = conv_geom_pkg::DEF_IMG_H
) (
	input  wire                       clk,
	input  wire                       i_reset,
	input  wire                       i_wr_en,
	input  wire  [11:0]               i_wr_addr,
	input  conv_arith_pkg::pixel_t    i_wr_data,
	input  wire                       i_win_valid,
	input  conv_geom_pkg::coord_t     i_win_row,
	input  conv_geom_pkg::coord_t     i_win_col,
	input  conv_geom_pkg::tap_mask_t  i_win_mask,
	input  wire                       i_win_last,
	output conv_arith_pkg::pixel_t    o_taps [conv_geom_pkg::TAPS],
	output logic                      o_valid,
	output logic                      o_last
);
	import conv_geom_pkg::*;
	import conv_arith_pkg::*;

	localparam int DEPTH  = IMG_W * IMG_H;
	localparam int ADDR_W = $clog2(DEPTH);

	pixel_t            mem [DEPTH];
	logic [ADDR_W-1:0] tap_addr [TAPS];

	// row-major image, addr = row * IMG_W + col
	always_ff @(posedge clk) begin
		if (i_wr_en)
			mem[i_wr_addr[ADDR_W-1:0]] <= i_wr_data;
	end

	// neighbour addresses around the window center
	// masked taps may wrap here, their data is dropped below
	always_comb begin
		for (int t = 0; t < TAPS; t++) begin
			tap_addr[t] = ADDR_W'((int'(i_win_row) + t / 3 - 1) * IMG_W
				+ int'(i_win_col) + t % 3 - 1);
		end
	end

	always_ff @(posedge clk) begin
		if (i_win_valid) begin
			for (int t = 0; t < TAPS; t++) begin
				o_taps[t] <= i_win_mask[t] ? mem[tap_addr[t]] : '0; // zero padding
			end
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			o_valid <= 1'b0;
			o_last  <= 1'b0;
		end else begin
			o_valid <= i_win_valid;
			o_last  <= i_win_valid && i_win_last;
		end
	end

endmodule

`default_nettype wire

/* window/scan_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl #(
	parameter int IMG_W = conv_geom_pkg::DEF_IMG_W,
	parameter int IMG_H = conv_geom_pkg::DEF_IMG_H
) (
	input  wire                       clk,
	input  wire                       i_reset,
	input  wire                       i_start,
	output logic                      o_busy,
	output logic                      o_win_valid,
	output conv_geom_pkg::coord_t     o_win_row,
	output conv_geom_pkg::coord_t     o_win_col,
	output conv_geom_pkg::tap_mask_t  o_win_mask,
	output logic                      o_win_last
);
	import conv_geom_pkg::*;

	localparam coord_t LAST_PROW = coord_t'(IMG_H / 2 - 1);
	localparam coord_t LAST_PCOL = coord_t'(IMG_W / 2 - 1);
	localparam coord_t LAST_ROW  = coord_t'(IMG_H - 1);
	localparam coord_t LAST_COL  = coord_t'(IMG_W - 1);
	localparam logic [2:0] DRAIN = 3'd4; // fetch + mac + pool stages after the last window

	scan_state_t state;
	coord_t      prow, pcol;  // pooled output position
	logic [1:0]  quad;        // quadrant within the 2x2 group
	logic [2:0]  drain_cnt;
	logic        dr, dc;
	logic        last_win;

	// quadrant order (0,0) (0,1) (1,1) (1,0)
	assign dr = quad[1];
	assign dc = quad[1] ^ quad[0];

	assign o_win_valid = (state == SCAN_RUN);
	assign o_win_row   = {prow[COORD_W-2:0], dr};
	assign o_win_col   = {pcol[COORD_W-2:0], dc};
	assign last_win    = (quad == 2'd3) && (pcol == LAST_PCOL) && (prow == LAST_PROW);
	assign o_win_last  = o_win_valid && last_win;
	assign o_busy      = (state == SCAN_RUN) || (drain_cnt != 3'd0);

	// clear taps that fall off the image edges
	always_comb begin
		o_win_mask = '1;
		for (int t = 0; t < TAPS; t++) begin
			if ((t / 3 == 0) && (o_win_row == '0))
				o_win_mask[t] = 1'b0;
			if ((t / 3 == 2) && (o_win_row == LAST_ROW))
				o_win_mask[t] = 1'b0;
			if ((t % 3 == 0) && (o_win_col == '0))
				o_win_mask[t] = 1'b0;
			if ((t % 3 == 2) && (o_win_col == LAST_COL))
				o_win_mask[t] = 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (i_reset) begin
			state     <= SCAN_IDLE;
			prow      <= '0;
			pcol      <= '0;
			quad      <= '0;
			drain_cnt <= '0;
		end else begin
			if (drain_cnt != 3'd0)
				drain_cnt <= drain_cnt - 3'd1;
			case (state)
				SCAN_IDLE: begin
					if (i_start && (drain_cnt == 3'd0)) begin // ignored while draining
						state <= SCAN_RUN;
						prow  <= '0;
						pcol  <= '0;
						quad  <= '0;
					end
				end
				SCAN_RUN: begin
					quad <= quad + 2'd1;
					if (quad == 2'd3) begin
						if (pcol == LAST_PCOL) begin
							pcol <= '0;
							if (prow == LAST_PROW) begin
								state     <= SCAN_IDLE;
								drain_cnt <= DRAIN;
							end else
								prow <= prow + coord_t'(1);
						end else
							pcol <= pcol + coord_t'(1);
					end
				end
				default: state <= SCAN_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

/* common/conv_arith_pkg.sv */
`default_nettype none

package conv_arith_pkg;

	typedef logic [7:0] pixel_t;         // feature map pixel, unsigned
	typedef logic signed [7:0] weight_t;
	typedef logic signed [15:0] bias_t;

	// nine 17-bit products plus bias need 20 bits, one spare
	typedef logic signed [20:0] acc_t;

	typedef logic [7:0] pool_t;          // after relu, shift and saturation

	// right shift applied to the accumulator before saturating to 8 bits
	localparam int DEF_OUT_SHIFT = 4;

endpackage

`default_nettype wire

/* common/conv_geom_pkg.sv */
`default_nettype none

package conv_geom_pkg;

	// row / column coordinates, enough for a 64x64 image
	localparam int COORD_W = 6;
	typedef logic [COORD_W-1:0] coord_t;

	// 3x3 window, taps numbered row-major from top-left
	localparam int TAPS = 9;
	typedef logic [TAPS-1:0] tap_mask_t; // 1 = tap inside image

	// write port target
	typedef enum logic [1:0] {
		WR_IMAGE  = 2'd0,
		WR_WEIGHT = 2'd1,
		WR_BIAS   = 2'd2
	} wr_sel_t;

	typedef enum logic {
		SCAN_IDLE = 1'b0,
		SCAN_RUN  = 1'b1
	} scan_state_t;

	localparam int DEF_IMG_W = 8;
	localparam int DEF_IMG_H = 8;

endpackage

`default_nettype wire
